//--- source/gf2_mul_cfg.svh
// ****************************************
// Size settings of the GF(2) multiplier,
// included by the package and the RTL
// ****************************************

`ifndef GF2_MUL_CFG_SVH
`define GF2_MUL_CFG_SVH

// Operand width in bits
`define GF2_FIELD_BITS 163

// Limb split, three limbs pad the operand to 165 bits
`define GF2_LIMB_BITS 55
`define GF2_LIMBS 3

// One multiplier bit is scanned per clock
`define GF2_SERIAL_CYCLES `GF2_LIMB_BITS

// Accepted start to done
`define GF2_LATENCY (`GF2_SERIAL_CYCLES + 2)

`endif

//--- source/gf2_mul_pkg.sv
// ****************************************
// Data types of the GF(2) multiplier,
// imported by every RTL module
// ****************************************

`include "gf2_mul_cfg.svh"

package gf2_mul_pkg;

	// One input polynomial
	typedef logic [`GF2_FIELD_BITS-1:0] operand_t;

	// One operand limb
	typedef logic [`GF2_LIMB_BITS-1:0] limb_t;

	// Carry-less product of two limbs, degree at most 2*(w-1)
	typedef logic [2*`GF2_LIMB_BITS-2:0] limb_prod_t;

	// XOR of limb products on one diagonal, no growth over limb_prod_t
	typedef logic [2*`GF2_LIMB_BITS-2:0] diag_t;

	// Unreduced product of two operands
	typedef logic [2*`GF2_FIELD_BITS-2:0] product_t;

endpackage

//--- source/limb_clmul.sv
// ****************************************
// Bit-serial carry-less multiplier of one
// limb pair, started by a launch pulse
// ****************************************

`timescale 1ns/10ps

`include "gf2_mul_cfg.svh"

module limb_clmul (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    launch,
	input  gf2_mul_pkg::limb_t      x,
	input  gf2_mul_pkg::limb_t      y,
	output gf2_mul_pkg::limb_prod_t prod,
	output logic                    prod_valid
);
	import gf2_mul_pkg::*;

	localparam int CNT_W = $clog2(`GF2_SERIAL_CYCLES);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`GF2_SERIAL_CYCLES - 1);

	limb_t            x_q;
	limb_t            y_q;
	limb_prod_t       acc;
	logic [CNT_W-1:0] bit_cnt;
	logic             running;

	// Bit counter and run flag
	always_ff @(posedge clk) begin
		if (rst) begin
			running    <= 1'b0;
			bit_cnt    <= '0;
			prod_valid <= 1'b0;
		end else if (launch) begin
			running    <= 1'b1;
			bit_cnt    <= '0;
			prod_valid <= 1'b0;
		end else if (running) begin
			bit_cnt <= bit_cnt + 1'b1;
			// Last multiplier bit scanned in this cycle
			if (bit_cnt == LAST_BIT) begin
				running    <= 1'b0;
				prod_valid <= 1'b1;
			end
		end else begin
			prod_valid <= 1'b0;
		end
	end

	// Operand capture and shift-and-XOR accumulation
	always_ff @(posedge clk) begin
		if (launch) begin
			x_q <= x;
			y_q <= y;
			acc <= '0;
		end else if (running && x_q[bit_cnt]) begin
			acc <= acc ^ (limb_prod_t'(y_q) << bit_cnt);
		end
	end

	// Holds until the next launch clears the accumulator
	assign prod = acc;

endmodule

//--- source/diagonal_bank.sv
// ****************************************
// Limb multipliers for a range of product
// diagonals, with registered diagonal sums
// ****************************************

`timescale 1ns/10ps

`include "gf2_mul_cfg.svh"

module diagonal_bank #(
	parameter int DIAG_LO = 0,
	parameter int DIAG_HI = 2
) (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      launch,
	input  gf2_mul_pkg::operand_t                     a,
	input  gf2_mul_pkg::operand_t                     b,
	output gf2_mul_pkg::diag_t [DIAG_HI-DIAG_LO:0]    diag_sums,
	output logic                                      diag_valid
);
	import gf2_mul_pkg::*;

	localparam int NUM_DIAGS = DIAG_HI - DIAG_LO + 1;
	localparam int PAD_BITS  = `GF2_LIMBS * `GF2_LIMB_BITS;

	logic [PAD_BITS-1:0]              a_pad;
	logic [PAD_BITS-1:0]              b_pad;
	limb_t                            a_limb [`GF2_LIMBS];
	limb_t                            b_limb [`GF2_LIMBS];
	limb_prod_t                       unit_prod [`GF2_LIMBS][`GF2_LIMBS];
	logic [`GF2_LIMBS*`GF2_LIMBS-1:0] unit_valid;
	diag_t [NUM_DIAGS-1:0]            next_sums;
	logic                             prod_ready;

	// Upper limb bits beyond the field width are zero
	assign a_pad = PAD_BITS'(a);
	assign b_pad = PAD_BITS'(b);

	for (genvar i = 0; i < `GF2_LIMBS; i++) begin : g_row
		assign a_limb[i] = a_pad[i*`GF2_LIMB_BITS +: `GF2_LIMB_BITS];
		assign b_limb[i] = b_pad[i*`GF2_LIMB_BITS +: `GF2_LIMB_BITS];

		for (genvar j = 0; j < `GF2_LIMBS; j++) begin : g_col
			if ((i + j >= DIAG_LO) && (i + j <= DIAG_HI)) begin : g_unit
				limb_clmul u_clmul (
					.clk        (clk),
					.rst        (rst),
					.launch     (launch),
					.x          (a_limb[i]),
					.y          (b_limb[j]),
					.prod       (unit_prod[i][j]),
					.prod_valid (unit_valid[i*`GF2_LIMBS+j])
				);
			end else begin : g_none
				// Pair belongs to the other bank
				assign unit_prod[i][j]             = '0;
				assign unit_valid[i*`GF2_LIMBS+j] = 1'b0;
			end
		end
	end

	// All units run in lock-step, any one of them marks completion
	assign prod_ready = |unit_valid;

	// XOR of all products with the same weight i+j
	always_comb begin
		next_sums = '0;
		for (int i = 0; i < `GF2_LIMBS; i++) begin
			for (int j = 0; j < `GF2_LIMBS; j++) begin
				if ((i + j >= DIAG_LO) && (i + j <= DIAG_HI)) begin
					next_sums[i+j-DIAG_LO] = next_sums[i+j-DIAG_LO] ^ unit_prod[i][j];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (prod_ready) begin
			diag_sums <= next_sums;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			diag_valid <= 1'b0;
		end else begin
			diag_valid <= prod_ready;
		end
	end

endmodule

//--- source/product_assembler.sv
// ****************************************
// Start gating, busy and done control, and
// the shifted merge of the diagonal sums
// ****************************************

`timescale 1ns/10ps

`include "gf2_mul_cfg.svh"

module product_assembler (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  start,
	input  gf2_mul_pkg::diag_t [`GF2_LIMBS-1:0]   low_sums,
	input  gf2_mul_pkg::diag_t [`GF2_LIMBS-2:0]   high_sums,
	input  logic                                  diag_valid,
	output logic                                  launch,
	output logic                                  busy,
	output logic                                  done,
	output gf2_mul_pkg::product_t                 c
);
	import gf2_mul_pkg::*;

	localparam int NUM_LOW  = `GF2_LIMBS;
	localparam int NUM_HIGH = `GF2_LIMBS - 1;

	product_t merged;

	// Start is taken only while idle, the done cycle counts as idle
	assign launch = start & ~busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (launch) begin
			busy <= 1'b1;
		end else if (diag_valid) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= diag_valid;
		end
	end

	// Diagonal k carries weight x^(55k)
	always_comb begin
		merged = '0;
		for (int k = 0; k < NUM_LOW; k++) begin
			merged = merged ^ (product_t'(low_sums[k]) << (k * `GF2_LIMB_BITS));
		end
		// Bits shifted past the top are always zero, the top limbs are padded
		for (int k = 0; k < NUM_HIGH; k++) begin
			merged = merged ^
				(product_t'(high_sums[k]) << ((k + NUM_LOW) * `GF2_LIMB_BITS));
		end
	end

	// Result holds until the next product completes
	always_ff @(posedge clk) begin
		if (rst) begin
			c <= '0;
		end else if (diag_valid) begin
			c <= merged;
		end
	end

endmodule

//--- source/gf2_mul_top.sv
// ****************************************
// GF(2) 163-bit polynomial multiplier,
// unreduced product, one start per result
// ****************************************

`timescale 1ns/10ps

`include "gf2_mul_cfg.svh"

module gf2_mul_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  gf2_mul_pkg::operand_t a,
	input  gf2_mul_pkg::operand_t b,
	output logic                  busy,
	output logic                  done,
	output gf2_mul_pkg::product_t c
);
	import gf2_mul_pkg::*;

	logic                       launch;
	diag_t [`GF2_LIMBS-1:0]     low_sums;
	diag_t [`GF2_LIMBS-2:0]     high_sums;
	logic                       high_valid;

	// Diagonals 0 to 2, runs in lock-step with the upper bank
	diagonal_bank #(
		.DIAG_LO (0),
		.DIAG_HI (`GF2_LIMBS - 1)
	) u_low_bank (
		.clk        (clk),
		.rst        (rst),
		.launch     (launch),
		.a          (a),
		.b          (b),
		.diag_sums  (low_sums),
		.diag_valid ()
	);

	// Diagonals 3 and 4
	diagonal_bank #(
		.DIAG_LO (`GF2_LIMBS),
		.DIAG_HI (2 * `GF2_LIMBS - 2)
	) u_high_bank (
		.clk        (clk),
		.rst        (rst),
		.launch     (launch),
		.a          (a),
		.b          (b),
		.diag_sums  (high_sums),
		.diag_valid (high_valid)
	);

	product_assembler u_assembler (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.low_sums   (low_sums),
		.high_sums  (high_sums),
		.diag_valid (high_valid),
		.launch     (launch),
		.busy       (busy),
		.done       (done),
		.c          (c)
	);

endmodule

//--- bench/gf2_mul_properties.sv
// ****************************************
// Control timing assertions of the GF(2)
// multiplier, bound into the top level
// ****************************************

`timescale 1ns/10ps

`include "gf2_mul_cfg.svh"

module gf2_mul_properties (
	input logic                  clk,
	input logic                  rst,
	input logic                  start,
	input logic                  busy,
	input logic                  done,
	input gf2_mul_pkg::product_t c
);

	// Control flags come out of reset low
	a_reset_idle: assert property (@(posedge clk) rst |=> (!busy && !done))
		else $error("busy or done is high in the cycle after reset");

	// Done is a single-cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Done follows an accepted start after the fixed latency
	a_latency: assert property (@(posedge clk) disable iff (rst)
		(start && !busy) |-> ##(`GF2_LATENCY + 1) done)
		else $error("done did not follow an accepted start after the expected latency");

	// Result holds while the multiplier is idle
	a_hold: assert property (@(posedge clk) disable iff (rst)
		(!busy && !done) |-> $stable(c))
		else $error("product changed while the multiplier was idle");

endmodule

bind gf2_mul_top gf2_mul_properties u_properties (.*);

//--- bench/gf2_mul_tb.sv
// ****************************************
// Directed testbench of the GF(2) multiplier,
// checks products against a shift-and-XOR model
// ****************************************

`timescale 1ns/10ps

`include "gf2_mul_cfg.svh"

module gf2_mul_tb;
	import gf2_mul_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT   = 2 * `GF2_LATENCY;
	localparam int RANDOM_PAIRS = 30;
	localparam int HOLD_CYCLES  = 20;
	// About 50 products of 57 cycles, reset and idle gaps, plus margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic     clk;
	logic     rst;
	logic     start;
	operand_t a;
	operand_t b;
	logic     busy;
	logic     done;
	product_t c;

	int          error_count;
	int          test_count;
	int          cycle_count;
	logic [15:0] lfsr_state;

	gf2_mul_top dut (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.a     (a),
		.b     (b),
		.busy  (busy),
		.done  (done),
		.c     (c)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run passed %0d clock cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	// Carry-less product, one shifted copy of y per set bit of x
	function automatic product_t clmul_ref(input operand_t x, input operand_t y);
		product_t r;
		r = '0;
		for (int i = 0; i < `GF2_FIELD_BITS; i++) begin
			if (x[i]) begin
				r = r ^ (product_t'(y) << i);
			end
		end
		return r;
	endfunction

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic next_random_operand(output operand_t value);
		for (int i = 0; i < `GF2_FIELD_BITS; i++) begin
			value[i]   = lfsr_state[15];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic operand_t alternating(input logic phase);
		operand_t r;
		for (int i = 0; i < `GF2_FIELD_BITS; i++) begin
			r[i] = ((i % 2) == 1) ^ phase;
		end
		return r;
	endfunction

	task automatic compare_product(input string name, input product_t expected,
		input product_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %b, actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_cycles(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("FAIL %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
			error_count++;
		end
	endtask

	// One-cycle start, returns at the falling edge after the launch edge
	task automatic launch_product(input operand_t op_a, input operand_t op_b);
		@(negedge clk);
		a     = op_a;
		b     = op_b;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Counts falling edges until done, optionally checking busy on the way
	task automatic wait_done(input logic check_busy, inout int cycles);
		while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
			if (check_busy) begin
				compare_bit("busy_until_done", 1'b1, busy);
			end
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("Error: done did not arrive within %0d cycles", WAIT_LIMIT);
			error_count++;
		end
	endtask

	task automatic multiply(input operand_t op_a, input operand_t op_b,
		output product_t result, output int cycles);
		launch_product(op_a, op_b);
		cycles = 0;
		wait_done(1'b0, cycles);
		result = c;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		$display("Test %s done with %0d errors", name, error_count - errors_before);
	endtask

	task automatic test_reset_state();
		int errors_before;
		errors_before = error_count;
		@(negedge clk);
		compare_bit("reset_busy", 1'b0, busy);
		compare_bit("reset_done", 1'b0, done);
		compare_product("reset_c", '0, c);
		report_test("reset_state", errors_before);
	endtask

	task automatic test_single_terms();
		int       errors_before;
		int       bit_pos [6];
		int       pa;
		int       pb;
		int       cycles;
		operand_t op_a;
		operand_t op_b;
		product_t expected;
		product_t result;
		errors_before = error_count;
		bit_pos = '{0, 54, 55, 109, 110, 162};
		next_random_operand(op_b);
		multiply(operand_t'(1), op_b, result, cycles);
		compare_product("identity", product_t'(op_b), result);
		// m = 0 squares a boundary bit, m = 1 pairs it with the next boundary
		for (int k = 0; k < 6; k++) begin
			for (int m = 0; m < 2; m++) begin
				pa = bit_pos[k];
				pb = bit_pos[(k + m) % 6];
				op_a = '0;
				op_b = '0;
				op_a[pa] = 1'b1;
				op_b[pb] = 1'b1;
				expected = '0;
				expected[pa + pb] = 1'b1;
				multiply(op_a, op_b, result, cycles);
				compare_product($sformatf("single_%0d_%0d", pa, pb), expected, result);
			end
		end
		report_test("single_terms", errors_before);
	endtask

	task automatic test_dense();
		int       errors_before;
		int       cycles;
		operand_t dense_a [4];
		operand_t dense_b [4];
		product_t result;
		errors_before = error_count;
		dense_a = '{'1, alternating(1'b0), '1, alternating(1'b1)};
		dense_b = '{'1, alternating(1'b1), alternating(1'b1), alternating(1'b1)};
		for (int k = 0; k < 4; k++) begin
			multiply(dense_a[k], dense_b[k], result, cycles);
			compare_product($sformatf("dense_%0d", k), clmul_ref(dense_a[k], dense_b[k]), result);
		end
		report_test("dense", errors_before);
	endtask

	task automatic test_random();
		int       errors_before;
		int       cycles;
		operand_t op_a;
		operand_t op_b;
		product_t result;
		errors_before = error_count;
		for (int k = 0; k < RANDOM_PAIRS; k++) begin
			next_random_operand(op_a);
			next_random_operand(op_b);
			multiply(op_a, op_b, result, cycles);
			compare_product($sformatf("random_%0d", k), clmul_ref(op_a, op_b), result);
			compare_cycles($sformatf("random_%0d_latency", k), `GF2_LATENCY, cycles);
		end
		report_test("random", errors_before);
	endtask

	task automatic test_start_while_busy();
		int       errors_before;
		int       cycles;
		operand_t a1;
		operand_t b1;
		operand_t a2;
		operand_t b2;
		errors_before = error_count;
		next_random_operand(a1);
		next_random_operand(b1);
		next_random_operand(a2);
		next_random_operand(b2);
		launch_product(a1, b1);
		cycles = 0;
		repeat (20) begin
			@(negedge clk);
			cycles++;
			compare_bit("busy_mid_run", 1'b1, busy);
		end
		// Second start with new operands, must be ignored
		a     = a2;
		b     = b2;
		start = 1'b1;
		@(negedge clk);
		cycles++;
		start = 1'b0;
		wait_done(1'b1, cycles);
		compare_product("ignored_start", clmul_ref(a1, b1), c);
		compare_cycles("ignored_start_latency", `GF2_LATENCY, cycles);
		compare_bit("busy_at_done", 1'b0, busy);
		@(negedge clk);
		compare_bit("idle_after_done", 1'b0, busy);
		report_test("start_while_busy", errors_before);
	endtask

	task automatic test_hold_back_to_back();
		int       errors_before;
		int       cycles;
		operand_t pair_a [3];
		operand_t pair_b [3];
		product_t result;
		errors_before = error_count;
		for (int k = 0; k < 3; k++) begin
			next_random_operand(pair_a[k]);
			next_random_operand(pair_b[k]);
		end
		multiply(pair_a[0], pair_b[0], result, cycles);
		compare_product("hold_first", clmul_ref(pair_a[0], pair_b[0]), result);
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			compare_product("hold_idle", clmul_ref(pair_a[0], pair_b[0]), c);
			compare_bit("hold_busy", 1'b0, busy);
		end
		multiply(pair_a[1], pair_b[1], result, cycles);
		compare_product("b2b_first", clmul_ref(pair_a[1], pair_b[1]), result);
		// Still in the done cycle, start the next product
		a     = pair_a[2];
		b     = pair_b[2];
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		compare_bit("b2b_accepted", 1'b1, busy);
		cycles = 0;
		wait_done(1'b0, cycles);
		compare_product("b2b_second", clmul_ref(pair_a[2], pair_b[2]), c);
		compare_cycles("b2b_second_latency", `GF2_LATENCY, cycles);
		report_test("hold_back_to_back", errors_before);
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		start       = 1'b0;
		a           = '0;
		b           = '0;
		error_count = 0;
		test_count  = 0;
		cycle_count = 0;
		lfsr_state  = 16'd66;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_reset_state();
		test_single_terms();
		test_dense();
		test_random();
		test_start_while_busy();
		test_hold_back_to_back();

		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- gf2_mul.f
+incdir+source
source/gf2_mul_pkg.sv
source/limb_clmul.sv
source/diagonal_bank.sv
source/product_assembler.sv
source/gf2_mul_top.sv
bench/gf2_mul_properties.sv
bench/gf2_mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the GF(2) multiplier testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert \
	--top-module gf2_mul_tb \
	-Mdir obj_dir \
	-f gf2_mul.f

if ! ./obj_dir/Vgf2_mul_tb > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error status"
	exit 1
fi
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	exit 1
fi
exit 0
